//--- hw/dispatchPkg.sv
// Shared field widths and checkpoint constants for the dispatch stage.
// Imported by wildcard in every RTL module header and by the testbench.
// The per-lane payload widths here must match the rename stage output.

`default_nettype none

package dispatchPkg;

  // instruction payload widths
  localparam int PC_W         = 32;  // program counter
  localparam int OPCODE_W     = 8;   // decoded opcode
  localparam int ARCH_REG_LOG = 5;   // architectural register index
  localparam int PHYS_REG_LOG = 7;   // physical register tag

  // branch checkpoints
  localparam int CHECKPOINTS    = 8;                     // one mask bit per checkpoint
  localparam int CHECKPOINT_LOG = $clog2(CHECKPOINTS);   // checkpoint id width

  // Mask of checkpoint bits that survive this cycle. A verified control
  // instruction frees its checkpoint, so that bit must be cleared in every
  // younger instruction's branch mask.
  function automatic logic [CHECKPOINTS-1:0] verifyKeepMask(
    input logic                      verified,
    input logic [CHECKPOINT_LOG-1:0] verifiedId
  );
    logic [CHECKPOINTS-1:0] keep;
    keep = '1;
    if (verified) begin
      keep[verifiedId] = 1'b0;  // checkpoint resolved correctly
    end
    return keep;
  endfunction

  // apply the keep mask to one lane's branch mask
  function automatic logic [CHECKPOINTS-1:0] applyKeepMask(
    input logic [CHECKPOINTS-1:0] mask,
    input logic [CHECKPOINTS-1:0] keep
  );
    return mask & keep;
  endfunction

endpackage

`default_nettype wire

//--- hw/dispatchBundleIf.sv
// Held dispatch bundle, shared between the bundle register and the capacity check.
// The bundle register drives the payload through modport store, the capacity
// check reads the lane flags and drives dispatch through modport check.

`timescale 1ns/1ps
`default_nettype none

interface dispatchBundleIf
  import dispatchPkg::*;
#(
  parameter int DISPATCH_WIDTH = 4
) ();

  logic                                           held;         // a bundle is in the register
  logic [DISPATCH_WIDTH-1:0]                      laneValid;
  logic [DISPATCH_WIDTH-1:0][PC_W-1:0]            pc;
  logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0]        opcode;
  logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0]    archDest;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    src1Phys;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    src2Phys;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    destPhys;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    oldDestPhys;
  logic [DISPATCH_WIDTH-1:0]                      isLoad;
  logic [DISPATCH_WIDTH-1:0]                      isStore;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]     branchMask;   // already cleared this cycle
  logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0]  checkpointId;
  logic                                           dispatch;     // bundle leaves at next edge

  modport store (
    output held, laneValid, pc, opcode, archDest,
    output src1Phys, src2Phys, destPhys, oldDestPhys,
    output isLoad, isStore, branchMask, checkpointId,
    input  dispatch
  );

  modport check (
    input  held, laneValid, isLoad, isStore,
    output dispatch
  );

endinterface

`default_nettype wire

//--- hw/dispatchBundleReg.sv
// Rename-to-dispatch bundle register.
// Accepts a bundle with a valid/ready handshake, holds it under back-pressure,
// clears verified checkpoint bits in the held and incoming branch masks, and
// drops the bundle on execute-stage recovery.

`timescale 1ns/1ps
`default_nettype none

module dispatchBundleReg
  import dispatchPkg::*;
#(
  parameter int DISPATCH_WIDTH = 4
) (
  input  logic                                          clk,
  input  logic                                          arstN_i,
  input  logic                                          renValid_i,
  output logic                                          renReady_o,
  input  logic [DISPATCH_WIDTH-1:0]                     renLaneValid_i,
  input  logic [DISPATCH_WIDTH-1:0][PC_W-1:0]           renPc_i,
  input  logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0]       renOpcode_i,
  input  logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0]   renArchDest_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renSrc1Phys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renSrc2Phys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renDestPhys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renOldDestPhys_i,
  input  logic [DISPATCH_WIDTH-1:0]                     renIsLoad_i,
  input  logic [DISPATCH_WIDTH-1:0]                     renIsStore_i,
  input  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]    renBranchMask_i,
  input  logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] renCheckpointId_i,
  input  logic                                          ctrlVerified_i,
  input  logic [CHECKPOINT_LOG-1:0]                     ctrlVerifiedId_i,
  input  logic                                          recoverEx_i,
  dispatchBundleIf.store                                bundle
);

  logic                                           heldQ;
  logic [DISPATCH_WIDTH-1:0]                      laneValidQ;
  logic [DISPATCH_WIDTH-1:0][PC_W-1:0]            pcQ;
  logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0]        opcodeQ;
  logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0]    archDestQ;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    src1PhysQ;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    src2PhysQ;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    destPhysQ;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]    oldDestPhysQ;
  logic [DISPATCH_WIDTH-1:0]                      isLoadQ;
  logic [DISPATCH_WIDTH-1:0]                      isStoreQ;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]     branchMaskQ;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0]  checkpointIdQ;

  logic [CHECKPOINTS-1:0]                         keepMask;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]     heldMaskUpd;  // held masks after verify
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]     renMaskUpd;   // incoming masks after verify
  logic                                           accept;

  // free slot now, or the held bundle leaves this cycle
  assign renReady_o = (~heldQ | bundle.dispatch) & ~recoverEx_i;
  assign accept     = renValid_i & renReady_o;

  assign keepMask = verifyKeepMask(ctrlVerified_i, ctrlVerifiedId_i);

  always_comb begin
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      heldMaskUpd[l] = applyKeepMask(branchMaskQ[l], keepMask);
      renMaskUpd[l]  = applyKeepMask(renBranchMask_i[l], keepMask);
    end
  end

  // occupancy and lane valids
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      heldQ      <= 1'b0;
      laneValidQ <= '0;
    end else if (recoverEx_i) begin
      heldQ      <= 1'b0;  // wrong-path bundle is dropped
      laneValidQ <= '0;
    end else if (accept) begin
      heldQ      <= 1'b1;
      laneValidQ <= renLaneValid_i;
    end else if (bundle.dispatch) begin
      heldQ      <= 1'b0;
      laneValidQ <= '0;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (accept) begin
      pcQ           <= renPc_i;
      opcodeQ       <= renOpcode_i;
      archDestQ     <= renArchDest_i;
      src1PhysQ     <= renSrc1Phys_i;
      src2PhysQ     <= renSrc2Phys_i;
      destPhysQ     <= renDestPhys_i;
      oldDestPhysQ  <= renOldDestPhys_i;
      isLoadQ       <= renIsLoad_i;
      isStoreQ      <= renIsStore_i;
      checkpointIdQ <= renCheckpointId_i;
      branchMaskQ   <= renMaskUpd;
    end else begin
      // stalled bundles still see checkpoints resolve
      branchMaskQ   <= heldMaskUpd;
    end
  end

  assign bundle.held         = heldQ;
  assign bundle.laneValid    = laneValidQ;
  assign bundle.pc           = pcQ;
  assign bundle.opcode       = opcodeQ;
  assign bundle.archDest     = archDestQ;
  assign bundle.src1Phys     = src1PhysQ;
  assign bundle.src2Phys     = src2PhysQ;
  assign bundle.destPhys     = destPhysQ;
  assign bundle.oldDestPhys  = oldDestPhysQ;
  assign bundle.isLoad       = isLoadQ;
  assign bundle.isStore      = isStoreQ;
  assign bundle.branchMask   = heldMaskUpd;  // same-cycle verify already applied
  assign bundle.checkpointId = checkpointIdQ;

endmodule

`default_nettype wire

//--- hw/dispatchCapacityCheck.sv
// Back-end room check for the held dispatch bundle.
// Counts valid loads, stores and lanes, compares them against the load queue,
// store queue, issue queue and active list occupancy, and decides dispatch.

`timescale 1ns/1ps
`default_nettype none

module dispatchCapacityCheck
  import dispatchPkg::*;
#(
  parameter int DISPATCH_WIDTH = 4,
  parameter int LSQ_SIZE       = 16,
  parameter int IQ_SIZE        = 32,
  parameter int AL_SIZE        = 64
) (
  input  logic [$clog2(LSQ_SIZE):0] loadQueueCnt_i,
  input  logic [$clog2(LSQ_SIZE):0] storeQueueCnt_i,
  input  logic [$clog2(IQ_SIZE):0]  issueQueueCnt_i,
  input  logic [$clog2(AL_SIZE):0]  activeListCnt_i,
  input  logic                      recoverEx_i,
  output logic                      stallFrontEnd_o,
  dispatchBundleIf.check            bundle
);

  localparam int LANE_CNT_W = $clog2(DISPATCH_WIDTH + 1);
  localparam int LSQ_SUM_W  = $clog2(LSQ_SIZE) + 2;  // one spare bit for the sum
  localparam int IQ_SUM_W   = $clog2(IQ_SIZE) + 2;
  localparam int AL_SUM_W   = $clog2(AL_SIZE) + 2;

  logic [LANE_CNT_W-1:0] loadCnt;
  logic [LANE_CNT_W-1:0] storeCnt;
  logic [LANE_CNT_W-1:0] laneCnt;

  logic [LSQ_SUM_W-1:0]  loadSum;
  logic [LSQ_SUM_W-1:0]  storeSum;
  logic [IQ_SUM_W-1:0]   issueSum;
  logic [AL_SUM_W-1:0]   activeSum;

  logic                  loadFits;
  logic                  storeFits;
  logic                  issueFits;
  logic                  activeFits;
  logic                  bundleFits;

  // only valid lanes claim back-end entries
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    laneCnt  = '0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      loadCnt  = loadCnt + LANE_CNT_W'(bundle.laneValid[l] & bundle.isLoad[l]);
      storeCnt = storeCnt + LANE_CNT_W'(bundle.laneValid[l] & bundle.isStore[l]);
      laneCnt  = laneCnt + LANE_CNT_W'(bundle.laneValid[l]);
    end
  end

  assign loadSum   = LSQ_SUM_W'(loadQueueCnt_i) + LSQ_SUM_W'(loadCnt);
  assign storeSum  = LSQ_SUM_W'(storeQueueCnt_i) + LSQ_SUM_W'(storeCnt);
  assign issueSum  = IQ_SUM_W'(issueQueueCnt_i) + IQ_SUM_W'(laneCnt);
  assign activeSum = AL_SUM_W'(activeListCnt_i) + AL_SUM_W'(laneCnt);

  assign loadFits   = loadSum <= LSQ_SUM_W'(LSQ_SIZE);
  assign storeFits  = storeSum <= LSQ_SUM_W'(LSQ_SIZE);
  assign issueFits  = issueSum <= IQ_SUM_W'(IQ_SIZE);
  assign activeFits = activeSum <= AL_SUM_W'(AL_SIZE);

  assign bundleFits = loadFits & storeFits & issueFits & activeFits;

  // the whole bundle goes, or none of it
  assign bundle.dispatch = bundle.held & bundleFits & ~recoverEx_i;
  assign stallFrontEnd_o = bundle.held & ~bundleFits;

endmodule

`default_nettype wire

//--- hw/dispatchTop.sv
// Dispatch stage top level.
// Takes renamed bundles from rename through a valid/ready handshake and sends
// each bundle whole to the back end once all queues have room.

`timescale 1ns/1ps
`default_nettype none

module dispatchTop
  import dispatchPkg::*;
#(
  parameter int DISPATCH_WIDTH = 4,
  parameter int LSQ_SIZE       = 16,
  parameter int IQ_SIZE        = 32,
  parameter int AL_SIZE        = 64
) (
  input  logic                                          clk,
  input  logic                                          arstN_i,
  // rename side
  input  logic                                          renValid_i,
  output logic                                          renReady_o,
  input  logic [DISPATCH_WIDTH-1:0]                     renLaneValid_i,
  input  logic [DISPATCH_WIDTH-1:0][PC_W-1:0]           renPc_i,
  input  logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0]       renOpcode_i,
  input  logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0]   renArchDest_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renSrc1Phys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renSrc2Phys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renDestPhys_i,
  input  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   renOldDestPhys_i,
  input  logic [DISPATCH_WIDTH-1:0]                     renIsLoad_i,
  input  logic [DISPATCH_WIDTH-1:0]                     renIsStore_i,
  input  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]    renBranchMask_i,
  input  logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] renCheckpointId_i,
  // back-end occupancy and control
  input  logic [$clog2(LSQ_SIZE):0]                     loadQueueCnt_i,
  input  logic [$clog2(LSQ_SIZE):0]                     storeQueueCnt_i,
  input  logic [$clog2(IQ_SIZE):0]                      issueQueueCnt_i,
  input  logic [$clog2(AL_SIZE):0]                      activeListCnt_i,
  input  logic                                          ctrlVerified_i,
  input  logic [CHECKPOINT_LOG-1:0]                     ctrlVerifiedId_i,
  input  logic                                          recoverEx_i,
  // back-end side
  output logic                                          dispValid_o,
  output logic [DISPATCH_WIDTH-1:0]                     dispLaneValid_o,
  output logic [DISPATCH_WIDTH-1:0][PC_W-1:0]           dispPc_o,
  output logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0]       dispOpcode_o,
  output logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0]   dispArchDest_o,
  output logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   dispSrc1Phys_o,
  output logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   dispSrc2Phys_o,
  output logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   dispDestPhys_o,
  output logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0]   dispOldDestPhys_o,
  output logic [DISPATCH_WIDTH-1:0]                     dispIsLoad_o,
  output logic [DISPATCH_WIDTH-1:0]                     dispIsStore_o,
  output logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]    dispBranchMask_o,
  output logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] dispCheckpointId_o,
  output logic                                          stallFrontEnd_o
);

  dispatchBundleIf #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) bundle ();

  dispatchBundleReg #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) i_bundleReg (
    .clk               (clk),
    .arstN_i           (arstN_i),
    .renValid_i        (renValid_i),
    .renReady_o        (renReady_o),
    .renLaneValid_i    (renLaneValid_i),
    .renPc_i           (renPc_i),
    .renOpcode_i       (renOpcode_i),
    .renArchDest_i     (renArchDest_i),
    .renSrc1Phys_i     (renSrc1Phys_i),
    .renSrc2Phys_i     (renSrc2Phys_i),
    .renDestPhys_i     (renDestPhys_i),
    .renOldDestPhys_i  (renOldDestPhys_i),
    .renIsLoad_i       (renIsLoad_i),
    .renIsStore_i      (renIsStore_i),
    .renBranchMask_i   (renBranchMask_i),
    .renCheckpointId_i (renCheckpointId_i),
    .ctrlVerified_i    (ctrlVerified_i),
    .ctrlVerifiedId_i  (ctrlVerifiedId_i),
    .recoverEx_i       (recoverEx_i),
    .bundle            (bundle.store)
  );

  dispatchCapacityCheck #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .LSQ_SIZE       (LSQ_SIZE),
    .IQ_SIZE        (IQ_SIZE),
    .AL_SIZE        (AL_SIZE)
  ) i_capacityCheck (
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .recoverEx_i     (recoverEx_i),
    .stallFrontEnd_o (stallFrontEnd_o),
    .bundle          (bundle.check)
  );

  assign dispValid_o        = bundle.dispatch;
  assign dispLaneValid_o    = bundle.laneValid;
  assign dispPc_o           = bundle.pc;
  assign dispOpcode_o       = bundle.opcode;
  assign dispArchDest_o     = bundle.archDest;
  assign dispSrc1Phys_o     = bundle.src1Phys;
  assign dispSrc2Phys_o     = bundle.src2Phys;
  assign dispDestPhys_o     = bundle.destPhys;
  assign dispOldDestPhys_o  = bundle.oldDestPhys;
  assign dispIsLoad_o       = bundle.isLoad;
  assign dispIsStore_o      = bundle.isStore;
  assign dispBranchMask_o   = bundle.branchMask;  // verified bit cleared
  assign dispCheckpointId_o = bundle.checkpointId;

endmodule

`default_nettype wire

//--- verif/dispatchTb.sv
// Directed testbench for the dispatch stage.
// Sends renamed bundles on falling edges, sets back-end occupancy, and checks
// dispatch, stall and handshake outputs against the queue capacity rule.

`timescale 1ns/1ps
`default_nettype none

module dispatchTb
  import dispatchPkg::*;
#(
  parameter int DISPATCH_WIDTH = 4,
  parameter int LSQ_SIZE       = 16,
  parameter int IQ_SIZE        = 32,
  parameter int AL_SIZE        = 64
) ();

  localparam int LSQ_CW         = $clog2(LSQ_SIZE) + 1;
  localparam int IQ_CW          = $clog2(IQ_SIZE) + 1;
  localparam int AL_CW          = $clog2(AL_SIZE) + 1;
  localparam int WIDEST         = DISPATCH_WIDTH * PC_W;  // widest compared value
  localparam int TIMEOUT        = 50;                     // cycles per wait
  localparam int RANDOM_BUNDLES = 40;

  logic clk, arstN_i, renValid_i, renReady_o, ctrlVerified_i, recoverEx_i;
  logic dispValid_o, stallFrontEnd_o;
  logic [DISPATCH_WIDTH-1:0] renLaneValid_i, renIsLoad_i, renIsStore_i;
  logic [DISPATCH_WIDTH-1:0] dispLaneValid_o, dispIsLoad_o, dispIsStore_o;
  logic [DISPATCH_WIDTH-1:0][PC_W-1:0] renPc_i, dispPc_o;
  logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0] renOpcode_i, dispOpcode_o;
  logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0] renArchDest_i, dispArchDest_o;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0] renSrc1Phys_i, renSrc2Phys_i, renDestPhys_i;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0] renOldDestPhys_i, dispSrc1Phys_o;
  logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0] dispSrc2Phys_o, dispDestPhys_o, dispOldDestPhys_o;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0] renBranchMask_i, dispBranchMask_o;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] renCheckpointId_i, dispCheckpointId_o;
  logic [LSQ_CW-1:0] loadQueueCnt_i, storeQueueCnt_i;
  logic [IQ_CW-1:0] issueQueueCnt_i;
  logic [AL_CW-1:0] activeListCnt_i;
  logic [CHECKPOINT_LOG-1:0] ctrlVerifiedId_i;

  logic [31:0] rngState;
  logic [CHECKPOINTS-1:0] clearedBits;  // checkpoints verified since the bundle was built
  int checks;
  int errors;
  int errorsAtTestStart;
  int dispSeen;  // dispatches seen at rising edges

  dispatchTop #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .LSQ_SIZE       (LSQ_SIZE),
    .IQ_SIZE        (IQ_SIZE),
    .AL_SIZE        (AL_SIZE)
  ) i_dispatchTop (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (dispValid_o) begin
      dispSeen++;
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic int randBelow(int n);
    return int'(nextRandom() % 32'(n));
  endfunction

  task automatic compareValue(string name, logic [WIDEST-1:0] got, logic [WIDEST-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkLanes(string name, logic [DISPATCH_WIDTH-1:0] got,
                            logic [DISPATCH_WIDTH-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkPc(string name, logic [DISPATCH_WIDTH-1:0][PC_W-1:0] got,
                         logic [DISPATCH_WIDTH-1:0][PC_W-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkOpcode(string name, logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0] got,
                             logic [DISPATCH_WIDTH-1:0][OPCODE_W-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkArch(string name, logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0] got,
                           logic [DISPATCH_WIDTH-1:0][ARCH_REG_LOG-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkPhys(string name, logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0] got,
                           logic [DISPATCH_WIDTH-1:0][PHYS_REG_LOG-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkMask(string name, logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0] got,
                           logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkId(string name, logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] got,
                         logic [DISPATCH_WIDTH-1:0][CHECKPOINT_LOG-1:0] exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask
  task automatic checkCount(string name, int got, int exp);
    compareValue(name, WIDEST'(got), WIDEST'(exp));
  endtask

  task automatic reportTest(string name);
    $display("%-16s %0d errors", name, errors - errorsAtTestStart);
    errorsAtTestStart = errors;
  endtask

  task automatic setCounts(int lq, int sq, int iq, int al);
    loadQueueCnt_i  = LSQ_CW'(lq);
    storeQueueCnt_i = LSQ_CW'(sq);
    issueQueueCnt_i = IQ_CW'(iq);
    activeListCnt_i = AL_CW'(al);
  endtask

  // random payload, caller picks lanes and memory ops
  task automatic buildBundle(logic [DISPATCH_WIDTH-1:0] lanes, logic [DISPATCH_WIDTH-1:0] loads,
                             logic [DISPATCH_WIDTH-1:0] stores);
    renLaneValid_i = lanes;
    renIsLoad_i    = loads;
    renIsStore_i   = stores;
    clearedBits    = '0;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      renPc_i[l]           = nextRandom();
      renOpcode_i[l]       = OPCODE_W'(nextRandom());
      renArchDest_i[l]     = ARCH_REG_LOG'(nextRandom());
      renSrc1Phys_i[l]     = PHYS_REG_LOG'(nextRandom());
      renSrc2Phys_i[l]     = PHYS_REG_LOG'(nextRandom());
      renDestPhys_i[l]     = PHYS_REG_LOG'(nextRandom());
      renOldDestPhys_i[l]  = PHYS_REG_LOG'(nextRandom());
      renBranchMask_i[l]   = CHECKPOINTS'(nextRandom());
      renCheckpointId_i[l] = CHECKPOINT_LOG'(nextRandom());
    end
  endtask

  // called on a falling edge, returns just after the falling edge that follows acceptance
  task automatic sendBundle();
    int waited;
    waited = 0;
    renValid_i = 1'b1;
    #1;
    while (!renReady_o && waited < TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!renReady_o) begin
      errors++;
      $display("timeout at %0t ns: rename handshake never became ready", $time);
    end
    @(negedge clk);
    renValid_i = 1'b0;
    #1;
  endtask

  task automatic checkStatus(logic expValid, logic expStall, logic expReady);
    checkBit("dispValid_o", dispValid_o, expValid);
    checkBit("stallFrontEnd_o", stallFrontEnd_o, expStall);
    checkBit("renReady_o", renReady_o, expReady);
  endtask

  task automatic checkBundle();
    logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0] expMask;
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      expMask[l] = renBranchMask_i[l] & ~clearedBits;  // verified bits drop out
    end
    checkLanes("dispLaneValid_o", dispLaneValid_o, renLaneValid_i);
    checkLanes("dispIsLoad_o", dispIsLoad_o, renIsLoad_i);
    checkLanes("dispIsStore_o", dispIsStore_o, renIsStore_i);
    checkPc("dispPc_o", dispPc_o, renPc_i);
    checkOpcode("dispOpcode_o", dispOpcode_o, renOpcode_i);
    checkArch("dispArchDest_o", dispArchDest_o, renArchDest_i);
    checkPhys("dispSrc1Phys_o", dispSrc1Phys_o, renSrc1Phys_i);
    checkPhys("dispSrc2Phys_o", dispSrc2Phys_o, renSrc2Phys_i);
    checkPhys("dispDestPhys_o", dispDestPhys_o, renDestPhys_i);
    checkPhys("dispOldDestPhys_o", dispOldDestPhys_o, renOldDestPhys_i);
    checkMask("dispBranchMask_o", dispBranchMask_o, expMask);
    checkId("dispCheckpointId_o", dispCheckpointId_o, renCheckpointId_i);
  endtask

  task automatic testPassthrough();
    logic [31:0] r;
    r = nextRandom();
    @(negedge clk);
    setCounts(0, 0, 0, 0);
    buildBundle('1, DISPATCH_WIDTH'(r), DISPATCH_WIDTH'(r >> 8) & ~DISPATCH_WIDTH'(r));
    sendBundle();
    checkStatus(1'b1, 1'b0, 1'b1);  // one cycle after acceptance
    checkBundle();
    @(negedge clk);
    #1;
    checkStatus(1'b0, 1'b0, 1'b1);
  endtask

  task automatic testLsqLimit();
    logic [DISPATCH_WIDTH-1:0] allLanes;
    int over;
    allLanes = '1;
    over = LSQ_SIZE - DISPATCH_WIDTH + 1;  // one entry short
    for (int q = 0; q < 2; q++) begin
      @(negedge clk);
      setCounts((q == 0) ? over : 0, (q == 1) ? over : 0, 0, 0);
      buildBundle(allLanes, (q == 0) ? allLanes : '0, (q == 1) ? allLanes : '0);
      sendBundle();
      checkStatus(1'b0, 1'b1, 1'b0);
      @(negedge clk);
      setCounts((q == 0) ? over - 1 : 0, (q == 1) ? over - 1 : 0, 0, 0);
      #1;
      checkStatus(1'b1, 1'b0, 1'b1);
      checkBundle();
    end
  endtask

  task automatic testPartialLimits();
    for (int q = 0; q < 3; q++) begin
      @(negedge clk);
      // q 0 fits exactly, q 1 and q 2 overflow issue queue and active list
      setCounts(0, 0, IQ_SIZE - 2 + ((q == 1) ? 1 : 0), AL_SIZE - 2 + ((q == 2) ? 1 : 0));
      buildBundle(DISPATCH_WIDTH'(5), '0, '0);  // lanes 0 and 2
      sendBundle();
      checkStatus(q == 0, q != 0, q == 0);
      if (q != 0) begin
        @(negedge clk);
        setCounts(0, 0, IQ_SIZE - 2, AL_SIZE - 2);
        #1;
        checkStatus(1'b1, 1'b0, 1'b1);
      end
      checkBundle();
    end
  endtask

  task automatic testBranchMask();
    logic [CHECKPOINT_LOG-1:0] id;
    id = CHECKPOINT_LOG'(nextRandom());
    @(negedge clk);
    setCounts(LSQ_SIZE, 0, 0, 0);  // full load queue holds the bundle
    buildBundle('1, '1, '0);
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      renBranchMask_i[l][id] = 1'b1;
    end
    sendBundle();
    checkStatus(1'b0, 1'b1, 1'b0);
    @(negedge clk);
    ctrlVerified_i   = 1'b1;
    ctrlVerifiedId_i = id;
    clearedBits[id]  = 1'b1;
    #1;
    checkBundle();  // cleared in the same cycle
    @(negedge clk);
    ctrlVerified_i = 1'b0;
    setCounts(0, 0, 0, 0);
    #1;
    checkStatus(1'b1, 1'b0, 1'b1);
    checkBundle();  // stored mask keeps it cleared
  endtask

  task automatic testRecovery();
    @(negedge clk);
    setCounts(LSQ_SIZE, 0, 0, 0);
    buildBundle('1, '1, '0);
    sendBundle();
    checkStatus(1'b0, 1'b1, 1'b0);
    @(negedge clk);
    recoverEx_i = 1'b1;
    setCounts(0, 0, 0, 0);  // room appears, but recovery wins
    #1;
    checkStatus(1'b0, 1'b0, 1'b0);
    @(negedge clk);
    recoverEx_i = 1'b0;
    #1;
    checkStatus(1'b0, 1'b0, 1'b1);
    @(negedge clk);
    buildBundle('1, '0, '0);
    sendBundle();
    checkStatus(1'b1, 1'b0, 1'b1);
    checkBundle();
  endtask

  task automatic testRandomRun();
    logic [31:0] r;
    logic [DISPATCH_WIDTH-1:0] lanes;
    logic [DISPATCH_WIDTH-1:0] loads;
    logic [DISPATCH_WIDTH-1:0] stores;
    int lq;
    int sq;
    int iq;
    int al;
    logic fits;
    int startSeen;
    @(negedge clk);
    startSeen = dispSeen;  // earlier bundles have left by now
    for (int n = 0; n < RANDOM_BUNDLES; n++) begin
      r = nextRandom();
      lanes  = DISPATCH_WIDTH'(r);
      loads  = DISPATCH_WIDTH'(r >> 8);
      stores = DISPATCH_WIDTH'(r >> 16) & ~loads;
      // occupancy near the top so both outcomes show up
      lq = LSQ_SIZE - randBelow(DISPATCH_WIDTH + 1);
      sq = LSQ_SIZE - randBelow(DISPATCH_WIDTH + 1);
      iq = IQ_SIZE - randBelow(DISPATCH_WIDTH + 1);
      al = AL_SIZE - randBelow(DISPATCH_WIDTH + 1);
      fits = (lq + $countones(lanes & loads) <= LSQ_SIZE)
          && (sq + $countones(lanes & stores) <= LSQ_SIZE)
          && (iq + $countones(lanes) <= IQ_SIZE)
          && (al + $countones(lanes) <= AL_SIZE);
      @(negedge clk);
      setCounts(lq, sq, iq, al);
      buildBundle(lanes, loads, stores);
      sendBundle();
      checkStatus(fits, !fits, fits);
      if (!fits) begin
        @(negedge clk);
        setCounts(0, 0, 0, 0);  // drain so the next bundle starts clean
        #1;
        checkStatus(1'b1, 1'b0, 1'b1);
      end
      checkBundle();
    end
    @(negedge clk);
    checkCount("dispatches", dispSeen - startSeen, RANDOM_BUNDLES);  // each bundle leaves once
  endtask

  initial begin
    rngState          = 32'h1f5e;
    checks            = 0;
    errors            = 0;
    errorsAtTestStart = 0;
    dispSeen          = 0;
    arstN_i           = 1'b0;
    renValid_i        = 1'b0;
    ctrlVerified_i    = 1'b0;
    ctrlVerifiedId_i  = '0;
    recoverEx_i       = 1'b0;
    setCounts(0, 0, 0, 0);
    buildBundle('0, '0, '0);
    repeat (16) @(negedge clk);
    arstN_i = 1'b1;
    #1;
    checkStatus(1'b0, 1'b0, 1'b1);
    reportTest("reset");
    testPassthrough();
    reportTest("passthrough");
    testLsqLimit();
    reportTest("lsq limit");
    testPartialLimits();
    reportTest("partial limits");
    testBranchMask();
    reportTest("branch mask");
    testRecovery();
    reportTest("recovery");
    testRandomRun();
    reportTest("random run");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hw/dispatchPkg.sv
hw/dispatchBundleIf.sv
hw/dispatchBundleReg.sv
hw/dispatchCapacityCheck.sv
hw/dispatchTop.sv
verif/dispatchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module dispatchTb -f all.f -Mdir obj_dir -o dispatchSim
./obj_dir/dispatchSim | tee sim.log
if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1
